/* udp_rx_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the UDP receive stage
// header bytes arrive in network order, byte 0 most significant
// the stream is one byte wide
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package udp_rx_pkg;

    // stream byte width
    localparam int byte_w = 8;

    // fixed UDP header size in bytes
    localparam int udp_hdr_bytes = 8;

    // decoded UDP header, field order as on the wire
    typedef struct packed {
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // byte view for capture, field view for decode
    typedef union packed {
        udp_hdr_t                                    fields;
        logic [0:udp_hdr_bytes-1][byte_w-1:0]        octet;
    } udp_hdr_u;

    // the IP fields that travel with the frame
    typedef struct packed {
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
        logic [7:0]  protocol;
    } ip_meta_t;

    // header leaving the stage
    typedef struct packed {
        ip_meta_t ip;
        udp_hdr_t udp;
    } rx_hdr_t;

    // one byte of stream with its sideband bits
    typedef struct packed {
        logic [byte_w-1:0] data;
        logic              last;
        logic              user;
    } axis_beat_t;

    // frame FSM states
    typedef enum logic [1:0] {
        idle,
        read_header,
        read_payload,
        read_payload_last
    } rx_state_t;

endpackage

/* udp_rx_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame FSM of the UDP receive stage
// s_payload_ready is the registered ready_early of the skid buffer
// a UDP length below 9 yields no trimming and flags a short payload
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module udp_rx_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   s_ip_hdr_valid,
    output logic                   s_ip_hdr_ready,
    input  udp_rx_pkg::axis_beat_t s_payload,
    input  logic                   s_payload_valid,
    output logic                   s_payload_ready,
    input  logic                   ready_early,
    input  logic                   hdr_pending,
    output udp_rx_pkg::axis_beat_t int_beat,
    output logic                   int_valid,
    output logic                   ip_store,
    output logic                   udp_done,
    output udp_rx_pkg::udp_hdr_t   udp_hdr,
    output logic                   error_header_early_termination,
    output logic                   error_payload_early_termination
);

    udp_rx_pkg::rx_state_t state_reg, state_next;
    udp_rx_pkg::udp_hdr_u  hdr_reg, hdr_next;

    logic [2:0]                    hdr_ptr_reg, hdr_ptr_next;
    logic [15:0]                   count_reg, count_next;
    logic [udp_rx_pkg::byte_w-1:0] last_data_reg;
    logic                          store_last;
    logic                          hdr_ready_next;
    logic                          payload_ready_next;
    logic                          err_hdr_next;
    logic                          err_payload_next;
    logic                          hdr_xfer;
    logic                          in_xfer;

    assign hdr_xfer = s_ip_hdr_valid && s_ip_hdr_ready;
    assign in_xfer  = s_payload_valid && s_payload_ready;

    // includes the byte being written, so the header is complete at udp_done
    assign udp_hdr = hdr_next.fields;

    always_comb begin
        state_next         = udp_rx_pkg::idle;
        hdr_ptr_next       = hdr_ptr_reg;
        count_next         = count_reg;
        hdr_next           = hdr_reg;
        hdr_ready_next     = 1'b0;
        payload_ready_next = 1'b0;
        store_last         = 1'b0;
        ip_store           = 1'b0;
        udp_done           = 1'b0;
        err_hdr_next       = 1'b0;
        err_payload_next   = 1'b0;
        int_beat           = s_payload;
        int_valid          = 1'b0;

        case (state_reg)
            udp_rx_pkg::idle: begin
                hdr_ptr_next   = '0;
                // wait until the last header has been taken
                hdr_ready_next = !hdr_pending;
                state_next     = udp_rx_pkg::idle;
                if (hdr_xfer) begin
                    hdr_ready_next     = 1'b0;
                    payload_ready_next = 1'b1;
                    ip_store           = 1'b1;
                    state_next         = udp_rx_pkg::read_header;
                end
            end
            udp_rx_pkg::read_header: begin
                payload_ready_next = 1'b1;
                state_next         = udp_rx_pkg::read_header;
                if (in_xfer) begin
                    hdr_next.octet[hdr_ptr_reg] = s_payload.data;
                    hdr_ptr_next = hdr_ptr_reg + 3'd1;
                    if (s_payload.last) begin
                        // frame ended inside the UDP header
                        err_hdr_next       = 1'b1;
                        payload_ready_next = 1'b0;
                        hdr_ready_next     = !hdr_pending;
                        state_next         = udp_rx_pkg::idle;
                    end else if (hdr_ptr_reg == 3'(udp_rx_pkg::udp_hdr_bytes - 1)) begin
                        udp_done           = 1'b1;
                        count_next         = hdr_next.fields.length
                                             - 16'(udp_rx_pkg::udp_hdr_bytes);
                        payload_ready_next = ready_early;
                        state_next         = udp_rx_pkg::read_payload;
                    end
                end
            end
            udp_rx_pkg::read_payload: begin
                payload_ready_next = ready_early;
                int_valid          = in_xfer;
                state_next         = udp_rx_pkg::read_payload;
                if (in_xfer) begin
                    count_next = count_reg - 16'd1;
                    if (s_payload.last) begin
                        if (count_reg != 16'd1) begin
                            // short payload, mark the final byte
                            int_beat.user    = 1'b1;
                            err_payload_next = 1'b1;
                        end
                        payload_ready_next = 1'b0;
                        hdr_ready_next     = !hdr_pending;
                        state_next         = udp_rx_pkg::idle;
                    end else if (count_reg == 16'd1) begin
                        // length reached early, keep byte until tlast
                        store_last = 1'b1;
                        int_valid  = 1'b0;
                        state_next = udp_rx_pkg::read_payload_last;
                    end
                end
            end
            udp_rx_pkg::read_payload_last: begin
                payload_ready_next = ready_early;
                int_beat.data      = last_data_reg;
                int_valid          = in_xfer && s_payload.last;
                state_next         = udp_rx_pkg::read_payload_last;
                // padding is read and dropped
                if (in_xfer && s_payload.last) begin
                    payload_ready_next = 1'b0;
                    hdr_ready_next     = !hdr_pending;
                    state_next         = udp_rx_pkg::idle;
                end
            end
            default: begin
                state_next = udp_rx_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg                       <= udp_rx_pkg::idle;
            hdr_ptr_reg                     <= '0;
            s_ip_hdr_ready                  <= 1'b0;
            s_payload_ready                 <= 1'b0;
            error_header_early_termination  <= 1'b0;
            error_payload_early_termination <= 1'b0;
        end else begin
            state_reg                       <= state_next;
            hdr_ptr_reg                     <= hdr_ptr_next;
            s_ip_hdr_ready                  <= hdr_ready_next;
            s_payload_ready                 <= payload_ready_next;
            error_header_early_termination  <= err_hdr_next;
            error_payload_early_termination <= err_payload_next;
        end

        hdr_reg   <= hdr_next;
        count_reg <= count_next;
        if (store_last) begin
            last_data_reg <= s_payload.data;
        end
    end

endmodule

/* udp_hdr_out.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// header output register
// holds one header only, the FSM must not store a new one while
// hdr_pending is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module udp_hdr_out (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ip_store,
    input  udp_rx_pkg::ip_meta_t s_ip_meta,
    input  logic                 udp_done,
    input  udp_rx_pkg::udp_hdr_t udp_hdr,
    output logic                 hdr_pending,
    output udp_rx_pkg::rx_hdr_t  m_hdr,
    output logic                 m_hdr_valid,
    input  logic                 m_hdr_ready
);

    udp_rx_pkg::rx_hdr_t hdr_reg;
    logic                valid_reg;

    assign m_hdr       = hdr_reg;
    assign m_hdr_valid = valid_reg;
    assign hdr_pending = valid_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_reg <= 1'b0;
        end else if (udp_done) begin
            valid_reg <= 1'b1;
        end else if (m_hdr_ready) begin
            // taken by the sink
            valid_reg <= 1'b0;
        end
    end

    // IP part at frame start, UDP part after the eighth byte
    always_ff @(posedge clk) begin
        if (ip_store) begin
            hdr_reg.ip <= s_ip_meta;
        end
        if (udp_done) begin
            hdr_reg.udp <= udp_hdr;
        end
    end

endmodule

/* udp_payload_skid.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-entry skid buffer for the payload stream
// the source must register ready_early and drive int_valid only
// while that registered copy is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module udp_payload_skid (
    input  logic                   clk,
    input  logic                   rst,
    input  udp_rx_pkg::axis_beat_t int_beat,
    input  logic                   int_valid,
    output logic                   ready_early,
    output udp_rx_pkg::axis_beat_t m_payload,
    output logic                   m_payload_valid,
    input  logic                   m_payload_ready
);

    udp_rx_pkg::axis_beat_t out_reg;
    udp_rx_pkg::axis_beat_t temp_reg;

    logic out_valid_reg, out_valid_next;
    logic temp_valid_reg, temp_valid_next;
    logic ready_reg;
    logic store_in_to_out;
    logic store_in_to_temp;
    logic store_temp_to_out;

    assign m_payload       = out_reg;
    assign m_payload_valid = out_valid_reg;

    // room next cycle unless temp fills or is already full
    assign ready_early = m_payload_ready
                         || (!temp_valid_reg && (!out_valid_reg || !int_valid));

    always_comb begin
        out_valid_next    = out_valid_reg;
        temp_valid_next   = temp_valid_reg;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (ready_reg) begin
            if (m_payload_ready || !out_valid_reg) begin
                out_valid_next  = int_valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_valid_next  = int_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (m_payload_ready) begin
            // drain temp into the output
            out_valid_next    = temp_valid_reg;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg  <= 1'b0;
            temp_valid_reg <= 1'b0;
            ready_reg      <= 1'b0;
        end else begin
            out_valid_reg  <= out_valid_next;
            temp_valid_reg <= temp_valid_next;
            ready_reg      <= ready_early;
        end

        if (store_in_to_out) begin
            out_reg <= int_beat;
        end else if (store_temp_to_out) begin
            out_reg <= temp_reg;
        end
        if (store_in_to_temp) begin
            temp_reg <= int_beat;
        end
    end

endmodule

/* udp_ip_rx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UDP receive stage, IP frame in, UDP frame out
// payload is trimmed to the UDP length, checksum is not verified
// error outputs are single-cycle pulses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module udp_ip_rx (
    input  logic                   clk,
    input  logic                   rst,
    // IP frame input
    input  logic                   s_ip_hdr_valid,
    output logic                   s_ip_hdr_ready,
    input  udp_rx_pkg::ip_meta_t   s_ip_meta,
    input  udp_rx_pkg::axis_beat_t s_payload,
    input  logic                   s_payload_valid,
    output logic                   s_payload_ready,
    // UDP frame output
    output udp_rx_pkg::rx_hdr_t    m_hdr,
    output logic                   m_hdr_valid,
    input  logic                   m_hdr_ready,
    output udp_rx_pkg::axis_beat_t m_payload,
    output logic                   m_payload_valid,
    input  logic                   m_payload_ready,
    // status
    output logic                   error_header_early_termination,
    output logic                   error_payload_early_termination
);

    udp_rx_pkg::axis_beat_t int_beat;
    udp_rx_pkg::udp_hdr_t   udp_hdr;

    logic int_valid;
    logic ready_early;
    logic ip_store;
    logic udp_done;
    logic hdr_pending;

    udp_rx_ctrl udp_rx_ctrl_inst (
        .clk                             (clk),
        .rst                             (rst),
        .s_ip_hdr_valid                  (s_ip_hdr_valid),
        .s_ip_hdr_ready                  (s_ip_hdr_ready),
        .s_payload                       (s_payload),
        .s_payload_valid                 (s_payload_valid),
        .s_payload_ready                 (s_payload_ready),
        .ready_early                     (ready_early),
        .hdr_pending                     (hdr_pending),
        .int_beat                        (int_beat),
        .int_valid                       (int_valid),
        .ip_store                        (ip_store),
        .udp_done                        (udp_done),
        .udp_hdr                         (udp_hdr),
        .error_header_early_termination  (error_header_early_termination),
        .error_payload_early_termination (error_payload_early_termination)
    );

    udp_hdr_out udp_hdr_out_inst (
        .clk         (clk),
        .rst         (rst),
        .ip_store    (ip_store),
        .s_ip_meta   (s_ip_meta),
        .udp_done    (udp_done),
        .udp_hdr     (udp_hdr),
        .hdr_pending (hdr_pending),
        .m_hdr       (m_hdr),
        .m_hdr_valid (m_hdr_valid),
        .m_hdr_ready (m_hdr_ready)
    );

    udp_payload_skid udp_payload_skid_inst (
        .clk             (clk),
        .rst             (rst),
        .int_beat        (int_beat),
        .int_valid       (int_valid),
        .ready_early     (ready_early),
        .m_payload       (m_payload),
        .m_payload_valid (m_payload_valid),
        .m_payload_ready (m_payload_ready)
    );

endmodule

/* udp_ip_rx_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protocol assertions for the UDP receive stage, bound to the top
// failures holds the number of fired assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module udp_ip_rx_checker (
    input logic                   clk,
    input logic                   rst,
    input logic                   s_ip_hdr_ready,
    input logic                   s_payload_ready,
    input udp_rx_pkg::rx_hdr_t    m_hdr,
    input logic                   m_hdr_valid,
    input logic                   m_hdr_ready,
    input udp_rx_pkg::axis_beat_t m_payload,
    input logic                   m_payload_valid,
    input logic                   m_payload_ready,
    input logic                   error_header_early_termination,
    input logic                   error_payload_early_termination
);

    int failures = 0;

    // stalled beat stays put
    payload_hold: assert property (@(posedge clk) disable iff (rst)
        m_payload_valid && !m_payload_ready |=> m_payload_valid && $stable(m_payload))
    else begin
        failures++;
        $error("payload beat changed while the output was stalled");
    end

    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=> m_hdr_valid && $stable(m_hdr))
    else begin
        failures++;
        $error("header changed while waiting for m_hdr_ready");
    end

    // error outputs are single pulses
    hdr_err_pulse: assert property (@(posedge clk) disable iff (rst)
        error_header_early_termination |=> !error_header_early_termination)
    else begin
        failures++;
        $error("header error output high for two cycles");
    end

    pay_err_pulse: assert property (@(posedge clk) disable iff (rst)
        error_payload_early_termination |=> !error_payload_early_termination)
    else begin
        failures++;
        $error("payload error output high for two cycles");
    end

    reset_quiet: assert property (@(posedge clk)
        $past(rst) |-> !(s_ip_hdr_ready || s_payload_ready || m_hdr_valid || m_payload_valid
                         || error_header_early_termination
                         || error_payload_early_termination))
    else begin
        failures++;
        $error("control output high during reset");
    end

endmodule

/* tb_udp_ip_rx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the UDP receive stage
// UDP lengths below 9 are not exercised
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_udp_ip_rx;

    // input bytes of all tests, back-pressure frames are at most 35 bytes
    localparam int total_bytes = 12 + 31 + 30 + 20 + 5 + 14 + 6 * 35;

    logic clk, rst;
    logic s_ip_hdr_valid, s_ip_hdr_ready, s_payload_valid, s_payload_ready;
    logic m_hdr_valid, m_hdr_ready, m_payload_valid, m_payload_ready;
    logic error_header_early_termination, error_payload_early_termination;
    udp_rx_pkg::ip_meta_t   s_ip_meta;
    udp_rx_pkg::axis_beat_t s_payload, m_payload;
    udp_rx_pkg::rx_hdr_t    m_hdr;

    udp_rx_pkg::axis_beat_t exp_beats[$];
    udp_rx_pkg::rx_hdr_t    exp_hdrs[$];
    logic [1:0] ready_pat [0:1023];
    integer seed;
    int errors, err_start, tests_run, tests_failed, cycle;
    int hdr_err_seen, pay_err_seen, exp_hdr_err, exp_pay_err;
    bit stall_mode;
    string test_name;

    udp_ip_rx udp_ip_rx_inst (.*);

    bind udp_ip_rx udp_ip_rx_checker udp_ip_rx_checker_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(total_bytes * 4 * 8 + 2000);
        $display("timeout: the DUT stopped moving data before all tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic check_beat();
        udp_rx_pkg::axis_beat_t exp;
        if (exp_beats.size() == 0) begin
            $display("%s: payload byte %h came out with none expected", test_name, m_payload.data);
            errors++;
        end else begin
            exp = exp_beats.pop_front();
            assert (m_payload == exp) else begin
                $display("** Error %s: payload expected %h/%b/%b, actual %h/%b/%b", test_name,
                         exp.data, exp.last, exp.user, m_payload.data, m_payload.last,
                         m_payload.user);
                errors++;
            end
        end
    endtask

    task automatic check_hdr();
        udp_rx_pkg::rx_hdr_t exp;
        if (exp_hdrs.size() == 0) begin
            $display("%s: a header came out with none expected", test_name);
            errors++;
        end else begin
            exp = exp_hdrs.pop_front();
            assert (m_hdr == exp) else begin
                $display("** Error %s: header expected %h, actual %h", test_name, exp, m_hdr);
                errors++;
            end
        end
    endtask

    // sink side, ready decided on the falling edge for the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            cycle++;
            m_payload_ready = !stall_mode || ready_pat[cycle % 1024][0];
            m_hdr_ready     = !stall_mode || ready_pat[cycle % 1024][1];
            if (m_payload_valid && m_payload_ready)
                check_beat();
            if (m_hdr_valid && m_hdr_ready)
                check_hdr();
            if (error_header_early_termination)
                hdr_err_seen++;
            if (error_payload_early_termination)
                pay_err_seen++;
        end
    end

    // hdr_cut above zero ends the frame after that many header bytes
    task automatic send_frame(input int udp_len, input int pay_len, input int pad_len,
                              input int hdr_cut);
        udp_rx_pkg::rx_hdr_t hdr;
        udp_rx_pkg::axis_beat_t beat;
        logic [7:0] bytes[$];
        int keep;
        hdr.ip.source_ip     = $random(seed);
        hdr.ip.dest_ip       = $random(seed);
        hdr.ip.protocol      = 8'($random(seed));
        hdr.udp.source_port  = 16'($random(seed));
        hdr.udp.dest_port    = 16'($random(seed));
        hdr.udp.length       = 16'(udp_len);
        hdr.udp.checksum     = 16'($random(seed));
        // network order, most significant byte first
        for (int i = 7; i >= 0; i--)
            bytes.push_back(hdr.udp[i*8 +: 8]);
        for (int i = 0; i < pay_len + pad_len; i++)
            bytes.push_back(8'($random(seed)));
        keep = (pay_len < udp_len - 8) ? pay_len : udp_len - 8;
        if (hdr_cut > 0) begin
            while (bytes.size() > hdr_cut)
                void'(bytes.pop_back());
            exp_hdr_err++;
        end else begin
            exp_hdrs.push_back(hdr);
            for (int i = 0; i < keep; i++) begin
                beat.data = bytes[8 + i];
                beat.last = (i == keep - 1);
                beat.user = (i == keep - 1) && (pay_len < udp_len - 8);
                exp_beats.push_back(beat);
            end
            if (pay_len < udp_len - 8)
                exp_pay_err++;
        end

        @(negedge clk);
        s_ip_hdr_valid = 1'b1;
        s_ip_meta      = hdr.ip;
        while (!s_ip_hdr_ready) @(negedge clk);
        @(negedge clk);
        s_ip_hdr_valid = 1'b0;
        foreach (bytes[i]) begin
            s_payload_valid = 1'b1;
            s_payload.data  = bytes[i];
            s_payload.last  = (i == bytes.size() - 1);
            s_payload.user  = 1'b0;
            while (!s_payload_ready) @(negedge clk);
            @(negedge clk);
        end
        s_payload_valid = 1'b0;
    endtask

    task automatic start_test(input string name, input bit stall);
        test_name    = name;
        stall_mode   = stall;
        err_start    = errors;
        hdr_err_seen = 0;
        pay_err_seen = 0;
        exp_hdr_err  = 0;
        exp_pay_err  = 0;
    endtask

    // done once everything expected is out and the next frame may start
    task automatic end_test();
        do @(posedge clk);
        while (exp_beats.size() != 0 || exp_hdrs.size() != 0 || !s_ip_hdr_ready);
        assert (hdr_err_seen == exp_hdr_err) else begin
            $display("** Error %s: header error pulses expected %0d, actual %0d", test_name,
                     exp_hdr_err, hdr_err_seen);
            errors++;
        end
        assert (pay_err_seen == exp_pay_err) else begin
            $display("** Error %s: payload error pulses expected %0d, actual %0d", test_name,
                     exp_pay_err, pay_err_seen);
            errors++;
        end
        tests_run++;
        if (errors == err_start) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, errors - err_start);
        end
    endtask

    initial begin
        int pay;
        int pad;
        seed = 32'h88b1_c8c3;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cycle = 0;
        stall_mode = 1'b0;
        rst = 1'b1;
        s_ip_hdr_valid = 1'b0;
        s_ip_meta = '0;
        s_payload = '0;
        s_payload_valid = 1'b0;
        m_hdr_ready = 1'b1;
        m_payload_ready = 1'b1;
        foreach (ready_pat[i])
            ready_pat[i] = 2'($random(seed));
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("header_decode", 1'b0);
        send_frame(12, 4, 0, 0);
        end_test();
        start_test("exact_length", 1'b0);
        send_frame(31, 23, 0, 0);
        end_test();
        start_test("trim_padding", 1'b0);
        send_frame(18, 10, 12, 0);
        end_test();
        start_test("short_payload", 1'b0);
        send_frame(38, 12, 0, 0);
        end_test();
        // cut header, then a clean frame right after
        start_test("short_header", 1'b0);
        send_frame(20, 0, 0, 5);
        send_frame(14, 6, 0, 0);
        end_test();
        start_test("back_pressure", 1'b1);
        repeat (6) begin
            pay = $unsigned($random(seed)) % 24 + 1;
            pad = $unsigned($random(seed)) % 4;
            send_frame(8 + pay, pay, pad, 0);
        end
        end_test();

        errors += udp_ip_rx_inst.udp_ip_rx_checker_inst.failures;
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* all.f */
udp_rx_pkg.sv
udp_rx_ctrl.sv
udp_hdr_out.sv
udp_payload_skid.sv
udp_ip_rx.sv
udp_ip_rx_checker.sv
tb_udp_ip_rx.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the UDP receive testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_udp_ip_rx

# keep running past assertion failures so the testbench reports them
result=$(./obj_dir/Vtb_udp_ip_rx +verilator+error+limit+1000 2>&1 || true)
echo "$result"

if echo "$result" | grep -qx "NO ERRORS"; then
    exit 0
else
    exit 1
fi
